// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_icmp_echo
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+.
icmp_pkg.sv
icmp_payload_ram.sv
icmp_echo_rx.sv
icmp_echo_tx.sv
icmp_echo_top.sv
icmp_echo_props.sv
tb_icmp_echo.sv

// ==== icmp_echo_props.sv ====
`timescale 1ns/1ns
`include "icmp_settings.svh"

module icmp_echo_props
(
    input logic clk,
    input logic rstn,
    input logic data_req,
    input logic mac_send_end,
    input logic tx_req,
    input logic tx_ready,
    input logic tx_end
);

    logic data_seen;   // data_req since the last send end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            data_seen <= 1'b0;
        else if (data_req)
            data_seen <= 1'b1;
        else if (mac_send_end)
            data_seen <= 1'b0;
    end

    // request and ready are separate phases
    req_ready_apart: assert property (@(posedge clk) disable iff (!rstn)
        !(tx_req && tx_ready))
        else $error("tx_req and tx_ready high in the same cycle");

    end_after_data: assert property (@(posedge clk) disable iff (!rstn)
        tx_end |-> data_seen)
        else $error("tx_end without an earlier data_req");

    req_low_after_reset: assert property (@(posedge clk) !rstn |=> !tx_req)
        else $error("tx_req high in the cycle after reset");

endmodule

// ==== icmp_echo_rx.sv ====
`timescale 1ns/1ns
`include "icmp_settings.svh"

// byte 0 of the message is on rx_data in the first cycle after rx_req,
// the rest follow back to back
module icmp_echo_rx
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      rx_req,
    input  logic [15:0]               rx_len,
    input  logic [7:0]                rx_data,
    input  logic                      rx_error,
    input  logic                      reply_done,
    output icmp_pkg::icmp_ram_wr_t    wr,
    output icmp_pkg::icmp_echo_info_t reply_info,
    output logic                      reply_start
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RECV,
        S_PAD,
        S_FOLD1,
        S_FOLD2,
        S_VERIFY,
        S_BUSY
    } state_t;

    state_t      state;
    logic [15:0] cnt;        // byte index in the message
    logic [7:0]  hi_byte;    // upper half of the current word
    logic [31:0] sum_chk;    // all words as received
    logic [31:0] sum_rep;    // words as the reply will carry them
    logic [15:0] word_in;
    logic [15:0] word_rep;
    logic [15:0] wr_off;
    logic        len_ok;
    logic        bad_byte;

    // one end-around carry step
    function automatic logic [31:0] fold(input logic [31:0] s);
        return {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
    endfunction

    assign len_ok = (rx_len >= 16'(`ICMP_MSG_MIN)) &&
                    (rx_len <= 16'(`ICMP_MSG_MIN + `ICMP_PAYLOAD_MAX));

    // receive error or a type other than echo request
    assign bad_byte = rx_error || (cnt == 16'd0 && rx_data != `ICMP_ECHO_REQUEST);

    assign word_in = {hi_byte, rx_data};
    assign wr_off  = cnt - 16'(`ICMP_HDR_LEN);

    always_comb
    begin
        case (cnt)
            16'd1:   word_rep = {`ICMP_ECHO_REPLY, rx_data};   // type rewritten
            16'd3:   word_rep = 16'h0000;                      // checksum field
            default: word_rep = word_in;
        endcase
    end

    // payload goes straight to the buffer
    always_comb
    begin
        wr.en   = (state == S_RECV) && (cnt >= 16'(`ICMP_HDR_LEN)) && !bad_byte;
        wr.addr = wr_off[`ICMP_ADDR_W-1:0];
        wr.data = rx_data;
    end

    ////////////////////
    // control
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state       <= S_IDLE;
            cnt         <= '0;
            reply_start <= 1'b0;
        end
        else
        begin
            reply_start <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    cnt <= '0;
                    if (rx_req && len_ok)
                        state <= S_RECV;
                end
                S_RECV:
                begin
                    cnt <= cnt + 16'd1;
                    if (bad_byte)
                        state <= S_IDLE;   // drop the rest
                    else if (cnt == reply_info.msg_len - 16'd1)
                        state <= S_PAD;
                end
                S_PAD:
                    state <= S_FOLD1;
                S_FOLD1:
                    state <= S_FOLD2;
                S_FOLD2:
                    state <= S_VERIFY;
                S_VERIFY:
                begin
                    if (sum_chk[15:0] == 16'hffff)
                    begin
                        reply_start <= 1'b1;
                        state       <= S_BUSY;
                    end
                    else
                        state <= S_IDLE;
                end
                S_BUSY:
                begin
                    // buffer holds one message until the reply is gone
                    if (reply_done)
                        state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    ////////////////////
    // header capture and checksums
    ////////////////////
    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                sum_chk <= '0;
                sum_rep <= '0;
                if (rx_req)
                    reply_info.msg_len <= rx_len;
            end
            S_RECV:
            begin
                if (!cnt[0])
                    hi_byte <= rx_data;
                else
                begin
                    sum_chk <= sum_chk + {16'h0000, word_in};
                    sum_rep <= sum_rep + {16'h0000, word_rep};
                end
                case (cnt)
                    16'd1:   reply_info.code      <= rx_data;
                    16'd4:   reply_info.id[15:8]  <= rx_data;
                    16'd5:   reply_info.id[7:0]   <= rx_data;
                    16'd6:   reply_info.seq[15:8] <= rx_data;
                    16'd7:   reply_info.seq[7:0]  <= rx_data;
                    default: ;
                endcase
            end
            S_PAD:
            begin
                if (reply_info.msg_len[0])   // odd length, zero low byte
                begin
                    sum_chk <= sum_chk + {16'h0000, hi_byte, 8'h00};
                    sum_rep <= sum_rep + {16'h0000, hi_byte, 8'h00};
                end
            end
            S_FOLD1, S_FOLD2:
            begin
                sum_chk <= fold(sum_chk);
                sum_rep <= fold(sum_rep);
            end
            S_VERIFY:
                reply_info.reply_checksum <= ~sum_rep[15:0];
            default: ;
        endcase
    end

endmodule

// ==== icmp_echo_top.sv ====
`timescale 1ns/1ns
`include "icmp_settings.svh"

module icmp_echo_top #(
    parameter int unsigned tx_timeout = `ICMP_TX_TIMEOUT
)
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        rx_req,
    input  logic [15:0] rx_len,
    input  logic [7:0]  rx_data,
    input  logic        rx_error,
    input  logic        ip_tx_ack,
    input  logic        data_req,
    input  logic        mac_send_end,
    output logic        tx_req,
    output logic        tx_ready,
    output logic [7:0]  tx_data,
    output logic        tx_end
);

    icmp_pkg::icmp_ram_wr_t    wr;
    icmp_pkg::icmp_echo_info_t reply_info;
    logic                      reply_start;
    logic                      reply_done;
    logic [`ICMP_ADDR_W-1:0]   rd_addr;
    logic [7:0]                rd_data;

    icmp_echo_rx u_rx (
        .clk         (clk),
        .rstn        (rstn),
        .rx_req      (rx_req),
        .rx_len      (rx_len),
        .rx_data     (rx_data),
        .rx_error    (rx_error),
        .reply_done  (reply_done),
        .wr          (wr),
        .reply_info  (reply_info),
        .reply_start (reply_start)
    );

    icmp_payload_ram u_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    icmp_echo_tx #(
        .timeout_cycles (tx_timeout)
    ) u_tx (
        .clk          (clk),
        .rstn         (rstn),
        .reply_start  (reply_start),
        .reply_info   (reply_info),
        .ip_tx_ack    (ip_tx_ack),
        .data_req     (data_req),
        .mac_send_end (mac_send_end),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .reply_done   (reply_done),
        .tx_req       (tx_req),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_end       (tx_end)
    );

endmodule

// ==== icmp_echo_tx.sv ====
`timescale 1ns/1ns
`include "icmp_settings.svh"

module icmp_echo_tx #(
    parameter int unsigned timeout_cycles = `ICMP_TX_TIMEOUT
)
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      reply_start,
    input  icmp_pkg::icmp_echo_info_t reply_info,
    input  logic                      ip_tx_ack,
    input  logic                      data_req,
    input  logic                      mac_send_end,
    input  logic [7:0]                rd_data,
    output logic [`ICMP_ADDR_W-1:0]   rd_addr,
    output logic                      reply_done,
    output logic                      tx_req,
    output logic                      tx_ready,
    output logic [7:0]                tx_data,
    output logic                      tx_end
);

    localparam int tmr_w = $clog2(timeout_cycles + 1);

    typedef enum logic [2:0] {
        T_IDLE,
        T_WAIT_ACK,
        T_READY,
        T_SEND,
        T_WAIT_END
    } state_t;

    state_t           state;
    logic [15:0]      cnt;         // reply byte index
    logic [tmr_w-1:0] timer;
    logic [15:0]      rd_off;
    logic             last_byte;
    logic [7:0]       next_byte;

    // address runs one byte ahead to cover the read latency
    assign rd_off    = cnt + 16'd1 - 16'(`ICMP_HDR_LEN);
    assign rd_addr   = rd_off[`ICMP_ADDR_W-1:0];
    assign last_byte = (cnt == reply_info.msg_len - 16'd1);

    always_comb
    begin
        case (cnt)
            16'd0:   next_byte = `ICMP_ECHO_REPLY;
            16'd1:   next_byte = reply_info.code;
            16'd2:   next_byte = reply_info.reply_checksum[15:8];
            16'd3:   next_byte = reply_info.reply_checksum[7:0];
            16'd4:   next_byte = reply_info.id[15:8];
            16'd5:   next_byte = reply_info.id[7:0];
            16'd6:   next_byte = reply_info.seq[15:8];
            16'd7:   next_byte = reply_info.seq[7:0];
            default: next_byte = rd_data;   // payload
        endcase
    end

    ////////////////////
    // handshake and serializer
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state      <= T_IDLE;
            cnt        <= '0;
            timer      <= '0;
            reply_done <= 1'b0;
            tx_req     <= 1'b0;
            tx_ready   <= 1'b0;
            tx_data    <= 8'h00;
            tx_end     <= 1'b0;
        end
        else
        begin
            reply_done <= 1'b0;
            tx_end     <= 1'b0;
            tx_data    <= 8'h00;
            case (state)
                T_IDLE:
                begin
                    cnt   <= '0;
                    timer <= '0;
                    if (reply_start)
                    begin
                        tx_req <= 1'b1;
                        state  <= T_WAIT_ACK;
                    end
                end
                T_WAIT_ACK:
                begin
                    // no limit here, the IP layer always answers
                    if (ip_tx_ack)
                    begin
                        tx_req   <= 1'b0;
                        tx_ready <= 1'b1;
                        state    <= T_READY;
                    end
                end
                T_READY:
                begin
                    timer <= timer + 1'b1;
                    if (data_req)
                    begin
                        tx_ready <= 1'b0;
                        state    <= T_SEND;
                    end
                    else if (timer == tmr_w'(timeout_cycles))
                    begin
                        tx_ready   <= 1'b0;
                        reply_done <= 1'b1;   // give up, free the buffer
                        state      <= T_IDLE;
                    end
                end
                T_SEND:
                begin
                    cnt     <= cnt + 16'd1;
                    tx_data <= next_byte;
                    tx_end  <= last_byte;
                    if (last_byte)
                        state <= T_WAIT_END;
                end
                T_WAIT_END:
                begin
                    if (mac_send_end)
                    begin
                        reply_done <= 1'b1;
                        state      <= T_IDLE;
                    end
                end
                default:
                    state <= T_IDLE;
            endcase
        end
    end

endmodule

// ==== icmp_payload_ram.sv ====
`timescale 1ns/1ns
`include "icmp_settings.svh"

module icmp_payload_ram
(
    input  logic                    clk,
    input  icmp_pkg::icmp_ram_wr_t  wr,
    input  logic [`ICMP_ADDR_W-1:0] rd_addr,
    output logic [7:0]              rd_data
);

    logic [7:0] mem [`ICMP_PAYLOAD_MAX];

    // simple dual port, read data one cycle after the address
    always_ff @(posedge clk)
    begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== icmp_pkg.sv ====
`include "icmp_settings.svh"

package icmp_pkg;

    // everything the transmitter needs to rebuild the reply header
    typedef struct packed {
        logic [7:0]  code;
        logic [15:0] id;
        logic [15:0] seq;
        logic [15:0] reply_checksum;   // already inverted
        logic [15:0] msg_len;          // header plus payload
    } icmp_echo_info_t;

    // one payload write into the buffer
    typedef struct packed {
        logic                    en;
        logic [`ICMP_ADDR_W-1:0] addr;   // offset behind the echo header
        logic [7:0]              data;
    } icmp_ram_wr_t;

endpackage

// ==== icmp_settings.svh ====
`ifndef ICMP_SETTINGS_SVH
`define ICMP_SETTINGS_SVH

// payload buffer geometry
`define ICMP_ADDR_W        8
`define ICMP_PAYLOAD_MAX   256

// message limits in bytes
`define ICMP_MSG_MIN       8
`define ICMP_HDR_LEN       8

// type codes
`define ICMP_ECHO_REQUEST  8'd8
`define ICMP_ECHO_REPLY    8'd0

// cycles with tx_ready high before an unanswered reply is abandoned
// default for the tx_timeout parameter of icmp_echo_top
`define ICMP_TX_TIMEOUT    1023

`endif

// ==== tb_icmp_echo.sv ====
`timescale 1ns/1ns
`include "icmp_settings.svh"

module tb_icmp_echo;

    localparam int msg_max = `ICMP_MSG_MIN + `ICMP_PAYLOAD_MAX;

    logic        clk;
    logic        rstn;
    logic        rx_req;
    logic [15:0] rx_len;
    logic [7:0]  rx_data;
    logic        rx_error;
    logic        ip_tx_ack;
    logic        data_req;
    logic        mac_send_end;
    logic        tx_req;
    logic        tx_ready;
    logic [7:0]  tx_data;
    logic        tx_end;

    int          seed = 30460;
    logic [7:0]  msg [msg_max];   // request bytes
    logic [7:0]  got [msg_max];   // reply bytes as seen on tx_data

    icmp_echo_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .rx_req       (rx_req),
        .rx_len       (rx_len),
        .rx_data      (rx_data),
        .rx_error     (rx_error),
        .ip_tx_ack    (ip_tx_ack),
        .data_req     (data_req),
        .mac_send_end (mac_send_end),
        .tx_req       (tx_req),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_end       (tx_end)
    );

    bind icmp_echo_top icmp_echo_props u_props (
        .clk          (clk),
        .rstn         (rstn),
        .data_req     (data_req),
        .mac_send_end (mac_send_end),
        .tx_req       (tx_req),
        .tx_ready     (tx_ready),
        .tx_end       (tx_end)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // folded ones-complement sum over msg, checksum field as zero
    function automatic logic [15:0] ones_sum(input int len, input logic [7:0] type_byte);
        logic [31:0] s;
        logic [7:0]  hi;
        logic [7:0]  lo;
        s = 32'h0;
        for (int i = 0; i < len; i += 2)
        begin
            hi = (i == 0) ? type_byte : msg[i];
            lo = (i + 1 < len) ? msg[i + 1] : 8'h00;   // pad odd length
            if (i == 2)
            begin
                hi = 8'h00;
                lo = 8'h00;
            end
            s = s + {16'h0000, hi, lo};
        end
        while (s[31:16] != 16'h0000)
            s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
        return s[15:0];
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input int idx);
        if (act !== exp)
            stop_run($sformatf("Mismatch at %0t: reply byte %0d is %02h, expected %02h",
                               $time, idx, act, exp));
    endtask

    task automatic check_header(input icmp_pkg::icmp_echo_info_t act,
                                input icmp_pkg::icmp_echo_info_t exp);
        if (act.msg_len !== exp.msg_len)
            stop_run($sformatf("Mismatch at %0t: reply length %0d, expected %0d",
                               $time, act.msg_len, exp.msg_len));
        if (act.code !== exp.code)
            stop_run($sformatf("Mismatch at %0t: code %02h, expected %02h",
                               $time, act.code, exp.code));
        if (act.reply_checksum !== exp.reply_checksum)
            stop_run($sformatf("Mismatch at %0t: checksum %04h, expected %04h",
                               $time, act.reply_checksum, exp.reply_checksum));
        if (act.id !== exp.id || act.seq !== exp.seq)
            stop_run($sformatf("Mismatch at %0t: id/seq %04h/%04h, expected %04h/%04h",
                               $time, act.id, act.seq, exp.id, exp.seq));
    endtask

    ////////////////////
    // request side
    ////////////////////
    task automatic build_msg(input int len, input logic [7:0] type_byte);
        logic [15:0] csum;
        for (int i = 0; i < len; i++)
            msg[i] = 8'(pick(256));
        msg[0] = type_byte;
        csum   = ~ones_sum(len, type_byte);
        msg[2] = csum[15:8];
        msg[3] = csum[7:0];
    endtask

    task automatic send_msg(input int len, input int err_at);
        @(negedge clk);
        rx_req = 1'b1;
        rx_len = 16'(len);
        for (int i = 0; i < len; i++)
        begin
            @(negedge clk);
            rx_req   = 1'b0;
            rx_data  = msg[i];
            rx_error = (i == err_at);   // drop marker
        end
        @(negedge clk);
        rx_data  = 8'h00;
        rx_error = 1'b0;
    endtask

    ////////////////////
    // IP layer side
    ////////////////////
    task automatic take_request();
        int cycles;
        cycles = 0;
        while (!tx_req)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 20)
                stop_run("tx_req did not rise after a valid request");
        end
        repeat (pick(5)) @(negedge clk);
        ip_tx_ack = 1'b1;
        @(negedge clk);
        ip_tx_ack = 1'b0;
        cycles    = 0;
        while (!tx_ready)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 4)
                stop_run("tx_ready did not rise after the acknowledge");
        end
    endtask

    task automatic expect_reply(input int len);
        icmp_pkg::icmp_echo_info_t exp;
        icmp_pkg::icmp_echo_info_t act;
        int n;
        exp.code           = msg[1];
        exp.id             = {msg[4], msg[5]};
        exp.seq            = {msg[6], msg[7]};
        exp.reply_checksum = ~ones_sum(len, `ICMP_ECHO_REPLY);
        exp.msg_len        = 16'(len);
        take_request();
        repeat (pick(6)) @(negedge clk);
        if (!tx_ready)
            stop_run("tx_ready dropped before data_req was raised");
        data_req = 1'b1;
        @(negedge clk);
        data_req = 1'b0;
        n = 0;
        do
        begin
            @(negedge clk);
            if (n >= msg_max)
                stop_run("reply ran past the longest message without tx_end");
            got[n] = tx_data;
            n++;
        end
        while (!tx_end);
        act.code           = got[1];
        act.reply_checksum = {got[2], got[3]};
        act.id             = {got[4], got[5]};
        act.seq            = {got[6], got[7]};
        act.msg_len        = 16'(n);
        check_header(act, exp);
        check_byte(got[0], `ICMP_ECHO_REPLY, 0);
        for (int i = `ICMP_HDR_LEN; i < len; i++)
            check_byte(got[i], msg[i], i);
        repeat (pick(4)) @(negedge clk);
        mac_send_end = 1'b1;
        @(negedge clk);
        mac_send_end = 1'b0;
        repeat (4) @(negedge clk);   // let rx leave busy
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            if (tx_req)
                stop_run("tx_req rose for a request that should have been dropped");
        end
    endtask

    task automatic expect_timeout();
        int cycles;
        take_request();
        cycles = 0;
        while (tx_ready)
        begin
            if (tx_end || tx_data !== 8'h00)
                stop_run("a reply byte went out without data_req");
            @(negedge clk);
            cycles++;
            if (cycles > `ICMP_TX_TIMEOUT + 8)
                stop_run("tx_ready did not fall after the reply timeout");
        end
        if (cycles < `ICMP_TX_TIMEOUT)
            stop_run($sformatf("tx_ready fell after only %0d cycles", cycles));
        expect_silence(8);
    endtask

    task automatic run_valid(input int len);
        build_msg(len, `ICMP_ECHO_REQUEST);
        send_msg(len, -1);
        expect_reply(len);
    endtask

    initial
    begin
        int         len;
        logic [7:0] bad_type;
        rstn         = 1'b0;
        rx_req       = 1'b0;
        rx_len       = 16'h0000;
        rx_data      = 8'h00;
        rx_error     = 1'b0;
        ip_tx_ack    = 1'b0;
        data_req     = 1'b0;
        mac_send_end = 1'b0;
        repeat (2) @(negedge clk);
        // outputs in reset
        if (tx_req !== 1'b0 || tx_ready !== 1'b0 || tx_end !== 1'b0 || tx_data !== 8'h00)
            stop_run($sformatf("Mismatch at %0t: outputs in reset req %b ready %b end %b data %02h",
                               $time, tx_req, tx_ready, tx_end, tx_data));
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        for (int k = 0; k < 6; k++)   // even lengths
            run_valid(`ICMP_MSG_MIN + 2 * int'(pick(129)));
        run_valid(`ICMP_MSG_MIN);      // header only
        run_valid(`ICMP_MSG_MIN + 1);
        run_valid(msg_max - 1);
        for (int k = 0; k < 5; k++)
            run_valid(`ICMP_MSG_MIN + 1 + 2 * int'(pick(128)));

        // wrong type
        len      = `ICMP_MSG_MIN + int'(pick(40));
        bad_type = 8'(pick(256));
        if (bad_type == `ICMP_ECHO_REQUEST)
            bad_type = 8'd13;
        build_msg(len, bad_type);
        send_msg(len, -1);
        expect_silence(len + 20);
        run_valid(`ICMP_MSG_MIN + int'(pick(60)));

        // corrupted checksum, then a receive error
        len = `ICMP_MSG_MIN + int'(pick(60));
        build_msg(len, `ICMP_ECHO_REQUEST);
        msg[2] = msg[2] ^ (8'h01 << pick(8));
        send_msg(len, -1);
        expect_silence(len + 20);
        run_valid(`ICMP_MSG_MIN + int'(pick(60)));
        len = `ICMP_MSG_MIN + int'(pick(60));
        build_msg(len, `ICMP_ECHO_REQUEST);
        send_msg(len, int'(pick(len)));
        expect_silence(len + 20);
        run_valid(`ICMP_MSG_MIN + int'(pick(60)));

        // no data_req at all
        len = `ICMP_MSG_MIN + int'(pick(60));
        build_msg(len, `ICMP_ECHO_REQUEST);
        send_msg(len, -1);
        expect_timeout();
        run_valid(`ICMP_MSG_MIN + int'(pick(60)));

        $display("TEST PASSED");
        $finish;
    end

endmodule
